// ==== filelist.f ====
+incdir+.
pu_bus_pkg.sv
pu_isa_pkg.sv
pu_instr_fetch.sv
pu_gpr_file.sv
pu_exec.sv
pu_mem_arbiter.sv
pu.sv
tb_pu_mem.sv
tb_pu.sv

// ==== pu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// halted_o stays high until reset. No interrupts, caches or MMU.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pu_defs.svh"

module pu (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  pu_bus_pkg::waddr_t   rstaddr_i,
	input  pu_bus_pkg::word_t    id_i,
	output pu_bus_pkg::mem_op_t  op_o,
	output pu_bus_pkg::waddr_t   addr_o,
	output pu_bus_pkg::word_t    data_o,
	input  pu_bus_pkg::word_t    data_i,
	input  logic                 rdy_i,
	output logic                 halted_o
);
	logic                 ireq, idone, ivalid, itake, flush;
	logic                 dreq, dwe, ddone, we;
	pu_bus_pkg::waddr_t   iaddr, daddr, target;
	pu_bus_pkg::word_t    idata, instr, dwdata, drdata;
	pu_bus_pkg::word_t    ra_data, rb_data, wd_data;
	pu_isa_pkg::gpr_idx_t ra, rb, wd_idx;

	pu_instr_fetch i_fetch (
		.clk_i, .reset_i, .rstaddr_i,
		.flush_i(flush), .target_i(target), .stop_i(halted_o), // Halt stops fetching.
		.ireq_o(ireq), .iaddr_o(iaddr), .idone_i(idone), .idata_i(idata),
		.ivalid_o(ivalid), .instr_o(instr), .itake_i(itake)
	);

	pu_exec i_exec (
		.clk_i, .reset_i, .id_i,
		.ivalid_i(ivalid), .instr_i(instr), .itake_o(itake),
		.flush_o(flush), .target_o(target), .halted_o,
		.ra_o(ra), .rb_o(rb), .ra_data_i(ra_data), .rb_data_i(rb_data),
		.we_o(we), .wd_idx_o(wd_idx), .wd_data_o(wd_data),
		.dreq_o(dreq), .dwe_o(dwe), .daddr_o(daddr), .dwdata_o(dwdata),
		.ddone_i(ddone), .drdata_i(drdata)
	);

	pu_gpr_file i_gpr (
		.clk_i, .reset_i,
		.ra_i(ra), .rb_i(rb), .ra_data_o(ra_data), .rb_data_o(rb_data),
		.we_i(we), .wd_idx_i(wd_idx), .wd_data_i(wd_data)
	);

	pu_mem_arbiter i_arb (
		.clk_i, .reset_i,
		.ireq_i(ireq), .iaddr_i(iaddr), .idone_o(idone), .idata_o(idata),
		.dreq_i(dreq), .dwe_i(dwe), .daddr_i(daddr), .dwdata_i(dwdata),
		.ddone_o(ddone), .drdata_o(drdata),
		.op_o, .addr_o, .data_o, .data_i, .rdy_i
	);

endmodule

// ==== pu_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory port types. Readwrite op exists but is never issued.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pu_defs.svh"

package pu_bus_pkg;

	typedef enum logic [1:0] {
		MEMNOOP        = 2'b00,
		MEMWRITEOP     = 2'b01,
		MEMREADOP      = 2'b10,
		MEMREADWRITEOP = 2'b11
	} mem_op_t;

	typedef logic [`PU_ARCHBITSZ-1:0] word_t;
	typedef logic [`PU_ADDRBITSZ-1:0] waddr_t; // Word address.

endpackage

// ==== pu_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core sizes. Word addressed, full words only, no byte selects.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PU_DEFS_SVH
`define PU_DEFS_SVH

// Data and instruction width.
`define PU_ARCHBITSZ 32

// Word address width, so the byte offset bits are gone.
`define PU_ADDRBITSZ 30

`define PU_GPRCNT 16 // General registers.

// Depth of the fetch ring.
`define PU_INSTRBUFSZ 2

`endif

// ==== pu_exec.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One instruction at a time. LD/ST hold issue until the bus completes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pu_defs.svh"

module pu_exec (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  pu_bus_pkg::word_t     id_i,
	input  logic                  ivalid_i,
	input  pu_bus_pkg::word_t     instr_i,
	output logic                  itake_o,
	output logic                  flush_o,
	output pu_bus_pkg::waddr_t    target_o,
	output logic                  halted_o,
	output pu_isa_pkg::gpr_idx_t  ra_o,
	output pu_isa_pkg::gpr_idx_t  rb_o,
	input  pu_bus_pkg::word_t     ra_data_i,
	input  pu_bus_pkg::word_t     rb_data_i,
	output logic                  we_o,
	output pu_isa_pkg::gpr_idx_t  wd_idx_o,
	output pu_bus_pkg::word_t     wd_data_o,
	output logic                  dreq_o,
	output logic                  dwe_o,
	output pu_bus_pkg::waddr_t    daddr_o,
	output pu_bus_pkg::word_t     dwdata_o,
	input  logic                  ddone_i,
	input  pu_bus_pkg::word_t     drdata_i
);
	localparam int IDXW = $bits(pu_isa_pkg::gpr_idx_t);

	pu_isa_pkg::opcode_t  opc;
	pu_isa_pkg::gpr_idx_t rd, ld_rd_q;
	pu_bus_pkg::word_t    simm, ea, alu_res, dwdata_q;
	pu_bus_pkg::waddr_t   daddr_q;
	logic                 issue, is_mem, alu_we;
	logic                 mem_q, dwe_q, halted_q;

	assign opc  = pu_isa_pkg::opcode_t'(instr_i[pu_isa_pkg::OPC_LSB +: 4]);
	assign rd   = instr_i[pu_isa_pkg::RD_LSB +: IDXW];
	assign ra_o = instr_i[pu_isa_pkg::RA_LSB +: IDXW];
	assign rb_o = instr_i[pu_isa_pkg::RB_LSB +: IDXW];
	assign simm = pu_bus_pkg::word_t'(signed'(instr_i[pu_isa_pkg::IMMBITSZ-1:0]));
	assign ea   = ra_data_i + simm; // Word address, upper bits dropped.

	assign issue   = ivalid_i && !halted_q && !mem_q;
	assign is_mem  = (opc == pu_isa_pkg::OP_LD) || (opc == pu_isa_pkg::OP_ST);
	assign itake_o = issue;

	always_comb begin
		alu_we  = 1'b1;
		alu_res = '0;
		case (opc)
			pu_isa_pkg::OP_LI:    alu_res = simm;
			pu_isa_pkg::OP_ADD:   alu_res = ra_data_i + rb_data_i;
			pu_isa_pkg::OP_SUB:   alu_res = ra_data_i - rb_data_i;
			pu_isa_pkg::OP_AND:   alu_res = ra_data_i & rb_data_i;
			pu_isa_pkg::OP_OR:    alu_res = ra_data_i | rb_data_i;
			pu_isa_pkg::OP_XOR:   alu_res = ra_data_i ^ rb_data_i;
			pu_isa_pkg::OP_GETID: alu_res = id_i;
			default:              alu_we  = 1'b0;
		endcase
	end

	// Jump target is absolute, zero extended.
	assign flush_o  = issue && (opc == pu_isa_pkg::OP_JZ) && (ra_data_i == '0);
	assign target_o = pu_bus_pkg::waddr_t'(instr_i[pu_isa_pkg::IMMBITSZ-1:0]);
	assign halted_o = halted_q;

	// Load completion owns the write port while a memory op is pending.
	assign we_o      = mem_q ? (ddone_i && !dwe_q) : (issue && alu_we);
	assign wd_idx_o  = mem_q ? ld_rd_q : rd;
	assign wd_data_o = mem_q ? drdata_i : alu_res;

	assign dreq_o   = mem_q;
	assign dwe_o    = dwe_q;
	assign daddr_o  = daddr_q;
	assign dwdata_o = dwdata_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			mem_q    <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			if (issue && is_mem) mem_q <= 1'b1;
			else if (ddone_i) mem_q <= 1'b0;
			if (issue && (opc == pu_isa_pkg::OP_HALT)) halted_q <= 1'b1; // Sticky.
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue) begin
			daddr_q  <= ea[`PU_ADDRBITSZ-1:0];
			dwdata_q <= rb_data_i;
			dwe_q    <= (opc == pu_isa_pkg::OP_ST);
			ld_rd_q  <= rd;
		end
	end

endmodule

// ==== pu_gpr_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads see a write only after the clock edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pu_defs.svh"

module pu_gpr_file (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  pu_isa_pkg::gpr_idx_t  ra_i,
	input  pu_isa_pkg::gpr_idx_t  rb_i,
	output pu_bus_pkg::word_t     ra_data_o,
	output pu_bus_pkg::word_t     rb_data_o,
	input  logic                  we_i,
	input  pu_isa_pkg::gpr_idx_t  wd_idx_i,
	input  pu_bus_pkg::word_t     wd_data_i
);
	pu_bus_pkg::word_t regs_q [`PU_GPRCNT];

	assign ra_data_o = regs_q[ra_i];
	assign rb_data_o = regs_q[rb_i];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `PU_GPRCNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i) begin
			regs_q[wd_idx_i] <= wd_data_i;
		end
	end

endmodule

// ==== pu_instr_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One fetch in flight at most. A flush drops that fetch when it lands.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pu_defs.svh"

module pu_instr_fetch (
	input  logic                clk_i,
	input  logic                reset_i,
	input  pu_bus_pkg::waddr_t  rstaddr_i,
	input  logic                flush_i,
	input  pu_bus_pkg::waddr_t  target_i,
	input  logic                stop_i,
	output logic                ireq_o,
	output pu_bus_pkg::waddr_t  iaddr_o,
	input  logic                idone_i,
	input  pu_bus_pkg::word_t   idata_i,
	output logic                ivalid_o,
	output pu_bus_pkg::word_t   instr_o,
	input  logic                itake_i
);
	localparam int PTRW = (`PU_INSTRBUFSZ > 1) ? $clog2(`PU_INSTRBUFSZ) : 1;
	localparam int CNTW = $clog2(`PU_INSTRBUFSZ + 1);

	pu_bus_pkg::word_t  ibuf [`PU_INSTRBUFSZ];
	logic [PTRW-1:0]    rd_ptr_q, wr_ptr_q;
	logic [CNTW-1:0]    cnt_q, cnt_nxt;
	pu_bus_pkg::waddr_t pc_q, faddr_q;
	logic               req_q, drop_q;
	logic               push, pop, start;

	function automatic logic [PTRW-1:0] ptr_inc(input logic [PTRW-1:0] p);
		return (p == PTRW'(`PU_INSTRBUFSZ - 1)) ? '0 : p + 1'b1;
	endfunction

	assign pop   = itake_i && (cnt_q != '0);
	assign push  = req_q && idone_i && !drop_q && !flush_i && !stop_i;
	assign cnt_nxt = cnt_q + CNTW'(push) - CNTW'(pop);
	// Next fetch may launch in the cycle the current one completes.
	assign start = !stop_i && !flush_i && (!req_q || idone_i) &&
		(cnt_nxt < CNTW'(`PU_INSTRBUFSZ));

	assign ireq_o   = req_q;
	assign iaddr_o  = faddr_q; // Held for the whole access.
	assign ivalid_o = (cnt_q != '0);
	assign instr_o  = ibuf[rd_ptr_q];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			req_q    <= 1'b0;
			drop_q   <= 1'b0;
			cnt_q    <= '0;
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			pc_q     <= rstaddr_i;
		end else if (flush_i) begin
			cnt_q    <= '0;
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			pc_q     <= target_i;
			req_q    <= req_q && !idone_i; // Bus still owes us this one.
			drop_q   <= req_q && !idone_i;
		end else begin
			if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
			cnt_q <= cnt_nxt;
			if (idone_i) drop_q <= 1'b0;
			if (start) begin
				req_q <= 1'b1;
				pc_q  <= pc_q + 1'b1;
			end else if (idone_i) begin
				req_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start) faddr_q <= pc_q;
		if (push) ibuf[wr_ptr_q] <= idata_i;
	end

endmodule

// ==== pu_isa_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set. Unknown opcodes run as NOP.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pu_defs.svh"

package pu_isa_pkg;

	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_LI    = 4'd1,  // rd = sext(imm).
		OP_ADD   = 4'd2,
		OP_SUB   = 4'd3,
		OP_AND   = 4'd4,
		OP_OR    = 4'd5,
		OP_XOR   = 4'd6,
		OP_LD    = 4'd7,  // rd = mem[ra + sext(imm)].
		OP_ST    = 4'd8,  // mem[ra + sext(imm)] = rb.
		OP_JZ    = 4'd9,  // if (ra == 0) pc = imm.
		OP_GETID = 4'd10,
		OP_HALT  = 4'd11
	} opcode_t;

	typedef logic [$clog2(`PU_GPRCNT)-1:0] gpr_idx_t;

	// Field positions, each field runs upward from its low bit.
	localparam int OPC_LSB  = 28;
	localparam int RD_LSB   = 24;
	localparam int RA_LSB   = 20;
	localparam int RB_LSB   = 16;
	localparam int IMMBITSZ = 16; // Immediate sits in the low half.

endpackage

// ==== pu_mem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Requesters must hold their request until done. Data wins at idle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pu_defs.svh"

module pu_mem_arbiter (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 ireq_i,
	input  pu_bus_pkg::waddr_t   iaddr_i,
	output logic                 idone_o,
	output pu_bus_pkg::word_t    idata_o,
	input  logic                 dreq_i,
	input  logic                 dwe_i,
	input  pu_bus_pkg::waddr_t   daddr_i,
	input  pu_bus_pkg::word_t    dwdata_i,
	output logic                 ddone_o,
	output pu_bus_pkg::word_t    drdata_o,
	output pu_bus_pkg::mem_op_t  op_o,
	output pu_bus_pkg::waddr_t   addr_o,
	output pu_bus_pkg::word_t    data_o,
	input  pu_bus_pkg::word_t    data_i,
	input  logic                 rdy_i
);
	logic busy_q, own_d_q;
	logic sel_d, active;

	// Owner is locked while busy, otherwise picked this cycle.
	assign sel_d  = busy_q ? own_d_q : dreq_i;
	assign active = busy_q || dreq_i || ireq_i;

	always_comb begin
		if (!active) op_o = pu_bus_pkg::MEMNOOP;
		else if (sel_d && dwe_i) op_o = pu_bus_pkg::MEMWRITEOP;
		else op_o = pu_bus_pkg::MEMREADOP;
	end

	assign addr_o = sel_d ? daddr_i : iaddr_i;
	assign data_o = dwdata_i; // Only sampled on writes.

	assign ddone_o  = active && sel_d && rdy_i;
	assign idone_o  = active && !sel_d && rdy_i;
	assign drdata_o = data_i;
	assign idata_o  = data_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q  <= 1'b0;
			own_d_q <= 1'b0;
		end else if (active) begin
			busy_q  <= !rdy_i;
			own_d_q <= sel_d;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary -sv --top-module tb_pu -f filelist.f -Mdir obj_dir -o tb_pu_sim; then
	echo "Verilator build failed."
	exit 1
fi

if ! ./obj_dir/tb_pu_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error."
	exit 1
fi
cat "$LOG"

if grep -qx "STATUS: PASS" "$LOG"; then
	echo "Run passed."
	exit 0
fi
echo "Run failed."
exit 1

// ==== tb_pu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed programs, each ends in HALT. Checks the port's writes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_pu;
	localparam int HALT_LIMIT = 2000;

	logic                clk, reset, rdy, halted;
	logic                clr, ld_en, rnd;
	pu_bus_pkg::waddr_t  rstaddr, addr, ld_addr, load_pc;
	pu_bus_pkg::word_t   id, wdata, rdata, ld_data;
	pu_bus_pkg::mem_op_t op;
	pu_bus_pkg::waddr_t  exp_addr [$];
	pu_bus_pkg::word_t   exp_data [$];
	int                  val_errs, other_errs;

	pu i_pu (
		.clk_i(clk), .reset_i(reset), .rstaddr_i(rstaddr), .id_i(id),
		.op_o(op), .addr_o(addr), .data_o(wdata), .data_i(rdata), .rdy_i(rdy),
		.halted_o(halted)
	);

	tb_pu_mem i_mem (
		.clk_i(clk), .reset_i(reset), .clr_i(clr), .ld_en_i(ld_en),
		.ld_addr_i(ld_addr), .ld_data_i(ld_data), .rnd_i(rnd),
		.op_i(op), .addr_i(addr), .data_i(wdata), .data_o(rdata), .rdy_o(rdy)
	);

	always #4 clk = ~clk;

	function automatic pu_bus_pkg::word_t enc(input pu_isa_pkg::opcode_t opc, input int rd,
		input int ra, input int rb, input int imm);
		return {opc, 4'(rd), 4'(ra), 4'(rb), 16'(imm)};
	endfunction

	function automatic pu_bus_pkg::word_t sext(input int imm);
		logic [15:0] h;
		h = 16'(imm);
		return {{16{h[15]}}, h};
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_word(input string name, input pu_bus_pkg::word_t exp,
		input pu_bus_pkg::word_t act);
		if (act !== exp) begin
			$display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_addr(input string name, input pu_bus_pkg::waddr_t exp,
		input pu_bus_pkg::waddr_t act);
		if (act !== exp) begin
			$display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR t=%0t %s exp=%0d act=%0d", $time, name, exp, act);
			val_errs++;
		end
	endtask

	// Puts the DUT in reset and clears memory, then programs load from base.
	task automatic start_prog(input int base);
		step();
		reset   = 1'b1;
		clr     = 1'b1;
		rstaddr = pu_bus_pkg::waddr_t'(base);
		load_pc = pu_bus_pkg::waddr_t'(base);
		exp_addr.delete();
		exp_data.delete();
		step();
		clr = 1'b0;
	endtask

	task automatic emit(input pu_bus_pkg::word_t w);
		ld_en   = 1'b1;
		ld_addr = load_pc;
		ld_data = w;
		step();
		ld_en   = 1'b0;
		load_pc = pu_bus_pkg::waddr_t'(load_pc + 1);
	endtask

	task automatic expect_write(input pu_bus_pkg::word_t ea, input pu_bus_pkg::word_t d);
		exp_addr.push_back(pu_bus_pkg::waddr_t'(ea)); // Upper bits of ra plus imm drop.
		exp_data.push_back(d);
	endtask

	task automatic run_prog(input logic rnd_mode, input string tname);
		int n;
		rnd = rnd_mode;
		repeat (16) step();
		reset = 1'b0;
		n = 0;
		while (!halted && n < HALT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			$display("%s: halted_o did not rise within %0d cycles", tname, HALT_LIMIT);
			other_errs++;
		end
	endtask

	task automatic check_writes(input string tname);
		int n;
		n = int'(i_mem.wr_cnt);
		check_count({tname, " write count"}, exp_addr.size(), n);
		for (int k = 0; k < exp_addr.size() && k < n; k++) begin
			check_addr($sformatf("%s wr_addr[%0d]", tname, k), exp_addr[k],
				i_mem.wr_addr[6'(k)]);
			check_word($sformatf("%s wr_data[%0d]", tname, k), exp_data[k],
				i_mem.wr_data[6'(k)]);
		end
	endtask

	task automatic test_alu(input logic rnd_mode);
		pu_bus_pkg::word_t a, b;
		a = sext('h1234);
		b = sext(-5);
		start_prog(0);
		emit(enc(pu_isa_pkg::OP_LI, 1, 0, 0, 'h1234));
		emit(enc(pu_isa_pkg::OP_LI, 2, 0, 0, -5));
		emit(enc(pu_isa_pkg::OP_ADD, 3, 1, 2, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 3, 'h40));
		emit(enc(pu_isa_pkg::OP_SUB, 4, 1, 2, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 4, 'h41));
		emit(enc(pu_isa_pkg::OP_AND, 5, 1, 2, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 5, 'h42));
		emit(enc(pu_isa_pkg::OP_OR, 6, 1, 2, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 6, 'h43));
		emit(enc(pu_isa_pkg::OP_XOR, 7, 1, 2, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 7, 'h44));
		emit(enc(pu_isa_pkg::OP_HALT, 0, 0, 0, 0));
		expect_write('h40, a + b);
		expect_write('h41, a - b);
		expect_write('h42, a & b);
		expect_write('h43, a | b);
		expect_write('h44, a ^ b);
		run_prog(rnd_mode, "alu");
		check_writes("alu");
	endtask

	task automatic test_ldst(input logic rnd_mode);
		pu_bus_pkg::word_t base, v;
		base = sext('h200);
		v = sext(-1234);
		start_prog(0);
		emit(enc(pu_isa_pkg::OP_LI, 1, 0, 0, 'h200));
		emit(enc(pu_isa_pkg::OP_LI, 2, 0, 0, -1234));
		emit(enc(pu_isa_pkg::OP_ST, 0, 1, 2, 5));
		emit(enc(pu_isa_pkg::OP_LD, 3, 1, 0, 5));
		emit(enc(pu_isa_pkg::OP_LI, 4, 0, 0, 3));
		emit(enc(pu_isa_pkg::OP_ADD, 3, 3, 4, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 1, 3, -2)); // Negative offset.
		emit(enc(pu_isa_pkg::OP_HALT, 0, 0, 0, 0));
		expect_write(base + sext(5), v);
		expect_write(base + sext(-2), v + sext(3));
		run_prog(rnd_mode, "ldst");
		check_writes("ldst");
	endtask

	// Sums n down to 1. Taken jumps skip prefetched ADDs and the final ST.
	task automatic test_loop(input logic rnd_mode);
		int n;
		n = 10;
		start_prog(0);
		emit(enc(pu_isa_pkg::OP_LI, 1, 0, 0, n));
		emit(enc(pu_isa_pkg::OP_LI, 3, 0, 0, -1));
		emit(enc(pu_isa_pkg::OP_JZ, 0, 1, 0, 6));
		emit(enc(pu_isa_pkg::OP_ADD, 2, 2, 1, 0));
		emit(enc(pu_isa_pkg::OP_ADD, 1, 1, 3, 0));
		emit(enc(pu_isa_pkg::OP_JZ, 0, 0, 0, 2)); // r0 stays zero, always taken.
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 2, 'h100));
		emit(enc(pu_isa_pkg::OP_HALT, 0, 0, 0, 0));
		expect_write('h100, pu_bus_pkg::word_t'(n * (n + 1) / 2));
		run_prog(rnd_mode, "loop");
		check_writes("loop");
	endtask

	task automatic test_getid();
		start_prog('h80);
		id = 32'h5eed_c0de;
		emit(enc(pu_isa_pkg::OP_GETID, 1, 0, 0, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 1, 'h300));
		emit(enc(pu_isa_pkg::OP_HALT, 0, 0, 0, 0));
		expect_write('h300, 32'h5eed_c0de);
		run_prog(1'b0, "getid");
		check_writes("getid");
		check_addr("getid first fetch addr", pu_bus_pkg::waddr_t'(32'h80), i_mem.first_raddr);
	endtask

	task automatic test_halt();
		start_prog(0);
		emit(enc(pu_isa_pkg::OP_LI, 1, 0, 0, 'h77));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 1, 'h50));
		emit(enc(pu_isa_pkg::OP_HALT, 0, 0, 0, 0));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 1, 'h51));
		emit(enc(pu_isa_pkg::OP_ST, 0, 0, 1, 'h52));
		expect_write('h50, sext('h77));
		run_prog(1'b1, "halt");
		for (int c = 0; c < 100; c++) begin
			@(negedge clk);
			if (!halted) begin
				$display("halt: halted_o fell while halted at %0t", $time);
				other_errs++;
			end
			if (op == pu_bus_pkg::MEMWRITEOP) begin
				$display("halt: write issued after HALT at %0t", $time);
				other_errs++;
			end
		end
		check_writes("halt");
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		rstaddr    = '0;
		id         = '0;
		clr        = 1'b0;
		ld_en      = 1'b0;
		ld_addr    = '0;
		ld_data    = '0;
		rnd        = 1'b0;
		load_pc    = '0;
		val_errs   = 0;
		other_errs = 0;
		test_alu(1'b0);
		test_ldst(1'b0);
		test_loop(1'b0);
		test_alu(1'b1); // Same programs with random ready delays.
		test_ldst(1'b1);
		test_loop(1'b1);
		test_getid();
		test_halt();
		$display("errors: value=%0d other=%0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb_pu_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 1024 words, address wraps. Keeps the first 64 writes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_pu_mem (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 clr_i,
	input  logic                 ld_en_i,
	input  pu_bus_pkg::waddr_t   ld_addr_i,
	input  pu_bus_pkg::word_t    ld_data_i,
	input  logic                 rnd_i,
	input  pu_bus_pkg::mem_op_t  op_i,
	input  pu_bus_pkg::waddr_t   addr_i,
	input  pu_bus_pkg::word_t    data_i,
	output pu_bus_pkg::word_t    data_o,
	output logic                 rdy_o
);
	localparam int AW    = 10;
	localparam int RECSZ = 64;

	pu_bus_pkg::word_t  mem [2**AW];
	pu_bus_pkg::waddr_t wr_addr [RECSZ];
	pu_bus_pkg::word_t  wr_data [RECSZ];
	logic [7:0]         wr_cnt;
	pu_bus_pkg::waddr_t first_raddr;
	logic               seen_rd;
	logic [1:0]         wait_q;
	logic [31:0]        lcg_q = 32'hba93eeee;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	assign data_o = mem[addr_i[AW-1:0]];
	assign rdy_o  = (op_i != pu_bus_pkg::MEMNOOP) && (wait_q == 2'd0);

	always @(posedge clk_i) begin
		if (clr_i) begin
			for (int a = 0; a < 2**AW; a++) begin
				mem[AW'(a)] <= 32'hb000_0000 | 32'(a); // HALT, low bits mark the address.
			end
		end else if (ld_en_i) begin
			mem[ld_addr_i[AW-1:0]] <= ld_data_i;
		end
		if (reset_i) begin
			wr_cnt  <= '0;
			seen_rd <= 1'b0;
			wait_q  <= 2'd0;
		end else if (op_i != pu_bus_pkg::MEMNOOP) begin
			if (wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else begin
				if (op_i == pu_bus_pkg::MEMWRITEOP) begin
					mem[addr_i[AW-1:0]] <= data_i;
					if (wr_cnt < 8'(RECSZ)) begin
						wr_addr[wr_cnt[5:0]] <= addr_i;
						wr_data[wr_cnt[5:0]] <= data_i;
					end
					wr_cnt <= wr_cnt + 8'd1;
				end else if (!seen_rd) begin
					first_raddr <= addr_i; // First fetch after reset.
					seen_rd     <= 1'b1;
				end
				// Delay for the next access, 0 to 3 cycles.
				lcg_q  <= lcg_next(lcg_q);
				wait_q <= rnd_i ? lcg_q[31:30] : 2'd0;
			end
		end
	end

endmodule
